// File: hw/uc_cce_top.sv
// Uncached CCE message path
`timescale 1ns/1ps

module uc_cce_top (
  input  logic                             clk_i,
  input  logic                             arst_n_i,

  // configuration levels
  input  logic [uc_pkg::cce_id_width-1:0]  cce_id_i,
  input  uc_pkg::cce_mode_e                cce_mode_i,

  // LCE requests in
  input  uc_pkg::lce_req_s                 lce_req_i,
  input  logic                             lce_req_v_i,
  output logic                             lce_req_ready_o,

  // memory responses in
  input  uc_pkg::mem_msg_s                 mem_resp_i,
  input  logic                             mem_resp_v_i,
  output logic                             mem_resp_ready_o,

  // LCE commands out
  output uc_pkg::lce_cmd_s                 lce_cmd_o,
  output logic                             lce_cmd_v_o,
  input  logic                             lce_cmd_ready_i,

  // memory commands out
  output uc_pkg::mem_msg_s                 mem_cmd_o,
  output logic                             mem_cmd_v_o,
  input  logic                             mem_cmd_ready_i
);

  import uc_pkg::*;

  // request buffer head toward the engine
  lce_req_s req_head;
  logic     req_head_v;
  logic     req_yumi;

  // response buffer head toward the engine
  mem_msg_s resp_head;
  logic     resp_head_v;
  logic     resp_yumi;

  // engine into the command buffer
  mem_msg_s cmd_in;
  logic     cmd_in_v;
  logic     cmd_in_ready;

  // command leaves the buffer when memory takes it
  logic     cmd_pop;

  assign cmd_pop = mem_cmd_v_o & mem_cmd_ready_i;

  // inbound LCE requests
  uc_msg_fifo #(.payload_t(lce_req_s)) req_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .data_i   (lce_req_i),
    .v_i      (lce_req_v_i),
    .ready_o  (lce_req_ready_o),
    .data_o   (req_head),
    .v_o      (req_head_v),
    .yumi_i   (req_yumi)
  );

  // inbound memory responses
  uc_msg_fifo #(.payload_t(mem_msg_s)) resp_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .data_i   (mem_resp_i),
    .v_i      (mem_resp_v_i),
    .ready_o  (mem_resp_ready_o),
    .data_o   (resp_head),
    .v_o      (resp_head_v),
    .yumi_i   (resp_yumi)
  );

  // forwarding engine between the buffers
  uc_fwd_engine engine (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .cce_id_i        (cce_id_i),
    .cce_mode_i      (cce_mode_i),
    .lce_req_i       (req_head),
    .lce_req_v_i     (req_head_v),
    .lce_req_yumi_o  (req_yumi),
    .mem_resp_i      (resp_head),
    .mem_resp_v_i    (resp_head_v),
    .mem_resp_yumi_o (resp_yumi),
    .lce_cmd_o       (lce_cmd_o),
    .lce_cmd_v_o     (lce_cmd_v_o),
    .lce_cmd_ready_i (lce_cmd_ready_i),
    .mem_cmd_o       (cmd_in),
    .mem_cmd_v_o     (cmd_in_v),
    .mem_cmd_ready_i (cmd_in_ready)
  );

  // outbound memory commands
  uc_msg_fifo #(.payload_t(mem_msg_s)) cmd_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .data_i   (cmd_in),
    .v_i      (cmd_in_v),
    .ready_o  (cmd_in_ready),
    .data_o   (mem_cmd_o),
    .v_o      (mem_cmd_v_o),
    .yumi_i   (cmd_pop)
  );

endmodule

// File: hw/uc_fwd_engine.sv
// Uncached forwarding engine
`timescale 1ns/1ps

module uc_fwd_engine (
  input  logic                             clk_i,
  input  logic                             arst_n_i,

  // static configuration
  input  logic [uc_pkg::cce_id_width-1:0]  cce_id_i,
  input  uc_pkg::cce_mode_e                cce_mode_i,

  // buffered LCE requests, valid then yumi
  input  uc_pkg::lce_req_s                 lce_req_i,
  input  logic                             lce_req_v_i,
  output logic                             lce_req_yumi_o,

  // buffered memory responses, valid then yumi
  input  uc_pkg::mem_msg_s                 mem_resp_i,
  input  logic                             mem_resp_v_i,
  output logic                             mem_resp_yumi_o,

  // outbound LCE commands, ready&valid
  output uc_pkg::lce_cmd_s                 lce_cmd_o,
  output logic                             lce_cmd_v_o,
  input  logic                             lce_cmd_ready_i,

  // outbound memory commands, ready&valid into the command buffer
  output uc_pkg::mem_msg_s                 mem_cmd_o,
  output logic                             mem_cmd_v_o,
  input  logic                             mem_cmd_ready_i
);

  import uc_pkg::*;

  // engine states
  typedef enum logic [1:0] {
    st_ready   = 2'd0,
    st_send_rd = 2'd1,
    st_send_wr = 2'd2
  } uc_state_e;

  uc_state_e state_r;
  uc_state_e state_n;

  // request captured when dequeued, held until memory takes it
  lce_req_s  req_r;

  // is the engine allowed to act this cycle
  logic      uc_active;

  // LCE size code to memory size code, one to one
  function automatic mem_size_e map_size(input uc_size_e size);
    mem_size_e res;
    begin
      case (size)
        e_uc_size_1: res = e_mem_size_1;
        e_uc_size_2: res = e_mem_size_2;
        e_uc_size_4: res = e_mem_size_4;
        default:     res = e_mem_size_8;
      endcase
      return res;
    end
  endfunction

  // memory command built from a held request
  // reads carry zero data, writes carry the store data
  function automatic mem_msg_s build_mem_cmd(input lce_req_s req, input logic is_wr);
    mem_msg_s cmd;
    begin
      cmd          = '0;
      cmd.msg_type = is_wr ? e_mem_uc_wr : e_mem_uc_rd;
      cmd.size     = map_size(req.uc_size);
      cmd.lce_id   = req.src_id;
      cmd.addr     = req.addr;
      if (is_wr) begin
        cmd.data = req.data;
      end
      return cmd;
    end
  endfunction

  // LCE command built from a memory response
  function automatic lce_cmd_s build_lce_cmd(
    input mem_msg_s                resp,
    input logic [cce_id_width-1:0] cce_id
  );
    lce_cmd_s cmd;
    begin
      cmd        = '0;
      // the lce id sent out with the command comes back here
      cmd.dst_id = resp.lce_id;
      cmd.addr   = resp.addr;
      if (resp.msg_type == e_mem_uc_rd) begin
        // load data back to the requester
        cmd.msg_type = e_lce_cmd_uc_data;
        cmd.data     = resp.data;
      end else begin
        // store acknowledged, tagged with our id
        cmd.msg_type = e_lce_cmd_uc_st_done;
        cmd.src_id   = cce_id;
      end
      return cmd;
    end
  endfunction

  // normal mode belongs to the microcoded path
  assign uc_active = (cce_mode_i == e_cce_mode_uncached);

  // state register
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= st_ready;
    end else begin
      state_r <= state_n;
    end
  end

  // request capture on dequeue
  always_ff @(posedge clk_i) begin
    if (lce_req_yumi_o) begin
      req_r <= lce_req_i;
    end
  end

  // next state and outputs
  always_comb begin
    lce_req_yumi_o  = 1'b0;
    mem_resp_yumi_o = 1'b0;
    lce_cmd_v_o     = 1'b0;
    lce_cmd_o       = '0;
    mem_cmd_v_o     = 1'b0;
    mem_cmd_o       = '0;
    // hold position while in normal mode, nothing is asserted
    state_n         = state_r;

    if (uc_active) begin
      case (state_r)
        st_ready: begin
          if (mem_resp_v_i) begin
            // responses win over new requests
            lce_cmd_v_o     = 1'b1;
            lce_cmd_o       = build_lce_cmd(mem_resp_i, cce_id_i);
            // drop the response only once the LCE side takes the command
            mem_resp_yumi_o = lce_cmd_ready_i;
          end else if (lce_req_v_i) begin
            // take the request, send it to memory next cycle
            lce_req_yumi_o = 1'b1;
            state_n        = (lce_req_i.msg_type == e_lce_req_uc_rd) ? st_send_rd
                                                                    : st_send_wr;
          end
        end

        st_send_rd: begin
          // uncached load toward memory
          mem_cmd_v_o = 1'b1;
          mem_cmd_o   = build_mem_cmd(req_r, 1'b0);
          if (mem_cmd_ready_i) begin
            state_n = st_ready;
          end
        end

        st_send_wr: begin
          // uncached store toward memory, data included
          mem_cmd_v_o = 1'b1;
          mem_cmd_o   = build_mem_cmd(req_r, 1'b1);
          if (mem_cmd_ready_i) begin
            state_n = st_ready;
          end
        end

        default: begin
          state_n = st_ready;
        end
      endcase
    end
  end

endmodule

// File: hw/uc_msg_fifo.sv
// Two-entry message buffer
`timescale 1ns/1ps

module uc_msg_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  // enqueue side, ready&valid
  input  payload_t data_i,
  input  logic     v_i,
  output logic     ready_o,
  // dequeue side, valid then yumi
  output payload_t data_o,
  output logic     v_o,
  input  logic     yumi_i
);

  // two payload slots
  payload_t   slots_r [2];

  // circular pointers, one bit each for two slots
  logic       wr_ptr_r;
  logic       rd_ptr_r;
  // occupancy, 0 to 2
  logic [1:0] count_r;

  logic       push;
  logic       pop;

  // beat accepted only while a slot is free
  assign push = v_i & ready_o;
  // consumer only raises yumi on a valid head
  assign pop  = yumi_i;

  // payload write
  always_ff @(posedge clk_i) begin
    if (push) begin
      slots_r[wr_ptr_r] <= data_i;
    end
  end

  // pointer and occupancy tracking
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      if (pop) begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      // push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count_r <= count_r + 2'd1;
        2'b01:   count_r <= count_r - 2'd1;
        default: count_r <= count_r;
      endcase
    end
  end

  // head comes straight out of the slot registers
  assign data_o  = slots_r[rd_ptr_r];
  assign v_o     = (count_r != 2'd0);
  // full means back-pressure
  assign ready_o = (count_r != 2'd2);

endmodule

// File: hw/uc_pkg.sv
// Uncached CCE message types

package uc_pkg;

  // id widths for local cache engines and the coherence engine
  localparam int lce_id_width = 2;
  localparam int cce_id_width = 2;

  // address and data word widths
  localparam int paddr_width = 32;
  localparam int dword_width = 64;

  // operating mode of the CCE
  // uncached runs before the coherence microcode is loaded
  typedef enum logic {
    e_cce_mode_uncached = 1'b0,
    e_cce_mode_normal   = 1'b1
  } cce_mode_e;

  // LCE request kinds handled on this path
  typedef enum logic {
    e_lce_req_uc_rd = 1'b0,
    e_lce_req_uc_wr = 1'b1
  } lce_req_type_e;

  // access size as the LCE encodes it
  typedef enum logic [1:0] {
    e_uc_size_1 = 2'b00,
    e_uc_size_2 = 2'b01,
    e_uc_size_4 = 2'b10,
    e_uc_size_8 = 2'b11
  } uc_size_e;

  // access size as memory encodes it
  typedef enum logic [1:0] {
    e_mem_size_1 = 2'b00,
    e_mem_size_2 = 2'b01,
    e_mem_size_4 = 2'b10,
    e_mem_size_8 = 2'b11
  } mem_size_e;

  // memory command kinds, echoed back in the memory response
  typedef enum logic {
    e_mem_uc_rd = 1'b0,
    e_mem_uc_wr = 1'b1
  } mem_cmd_type_e;

  // LCE command kinds sent back toward the requester
  typedef enum logic {
    e_lce_cmd_uc_data    = 1'b0,
    e_lce_cmd_uc_st_done = 1'b1
  } lce_cmd_type_e;

  // LCE request, 101 bits
  // data only meaningful for uc_wr
  typedef struct packed {
    logic [lce_id_width-1:0] src_id;
    lce_req_type_e           msg_type;
    uc_size_e                uc_size;
    logic [paddr_width-1:0]  addr;
    logic [dword_width-1:0]  data;
  } lce_req_s;

  // memory message, 101 bits
  // same layout for commands to memory and responses from memory
  // lce_id rides along so the response can find its requester
  typedef struct packed {
    mem_cmd_type_e           msg_type;
    mem_size_e               size;
    logic [lce_id_width-1:0] lce_id;
    logic [paddr_width-1:0]  addr;
    logic [dword_width-1:0]  data;
  } mem_msg_s;

  // LCE command, 101 bits
  // uc_data: data holds the load word, src_id zero
  // uc_st_done: data zero, src_id is the CCE id
  typedef struct packed {
    logic [lce_id_width-1:0] dst_id;
    logic [cce_id_width-1:0] src_id;
    lce_cmd_type_e           msg_type;
    logic [paddr_width-1:0]  addr;
    logic [dword_width-1:0]  data;
  } lce_cmd_s;

endpackage

// File: project.f
hw/uc_pkg.sv
hw/uc_msg_fifo.sv
hw/uc_fwd_engine.sv
hw/uc_cce_top.sv
verification/uc_cce_checker.sv
verification/uc_cce_tb.sv

// File: verification/uc_cce_checker.sv
// Uncached CCE checker
`timescale 1ns/1ps

module uc_cce_checker (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic [uc_pkg::cce_id_width-1:0] cce_id_i,
  input  uc_pkg::cce_mode_e               cce_mode_i,
  // accepted beats on the two inbound ports
  input  uc_pkg::lce_req_s                req_i,
  input  logic                            req_fire_i,
  input  uc_pkg::mem_msg_s                resp_i,
  input  logic                            resp_fire_i,
  // outbound ports, valid and ready seen separately
  input  uc_pkg::lce_cmd_s                lce_cmd_i,
  input  logic                            lce_cmd_v_i,
  input  logic                            lce_cmd_ready_i,
  input  uc_pkg::mem_msg_s                mem_cmd_i,
  input  logic                            mem_cmd_v_i,
  input  logic                            mem_cmd_ready_i,
  output int                              value_errors_o,
  output int                              other_errors_o
);

  import uc_pkg::*;

  // expected outputs, oldest first
  mem_msg_s exp_mem_q[$];
  lce_cmd_s exp_lce_q[$];
  mem_msg_s exp_mem;
  lce_cmd_s exp_lce;

  // memory command that an LCE request turns into
  function automatic mem_msg_s expected_mem_cmd(input lce_req_s req);
    mem_msg_s m;
    m        = '0;
    m.lce_id = req.src_id;
    m.addr   = req.addr;
    case (req.uc_size)
      e_uc_size_1: m.size = e_mem_size_1;
      e_uc_size_2: m.size = e_mem_size_2;
      e_uc_size_4: m.size = e_mem_size_4;
      default:     m.size = e_mem_size_8;
    endcase
    // loads go out with zero data
    if (req.msg_type == e_lce_req_uc_wr) begin
      m.msg_type = e_mem_uc_wr;
      m.data     = req.data;
    end else begin
      m.msg_type = e_mem_uc_rd;
    end
    return m;
  endfunction

  // LCE command that a memory response turns into
  function automatic lce_cmd_s expected_lce_cmd(input mem_msg_s resp, input logic [1:0] id);
    lce_cmd_s c;
    c        = '0;
    c.dst_id = resp.lce_id;
    c.addr   = resp.addr;
    if (resp.msg_type == e_mem_uc_rd) begin
      c.msg_type = e_lce_cmd_uc_data;
      c.data     = resp.data;
    end else begin
      // store done is tagged with the CCE id, no data
      c.msg_type = e_lce_cmd_uc_st_done;
      c.src_id   = id;
    end
    return c;
  endfunction

  initial begin
    value_errors_o = 0;
    other_errors_o = 0;
  end

  always @(posedge clk_i) begin
    if (arst_n_i) begin
      if (req_fire_i) begin
        exp_mem_q.push_back(expected_mem_cmd(req_i));
      end
      if (resp_fire_i) begin
        exp_lce_q.push_back(expected_lce_cmd(resp_i, cce_id_i));
      end
      // memory commands in request order
      if (mem_cmd_v_i && mem_cmd_ready_i) begin
        if (exp_mem_q.size() == 0) begin
          $display("memory command at %0t with no request behind it", $time);
          other_errors_o++;
        end else begin
          exp_mem = exp_mem_q.pop_front();
          if (mem_cmd_i !== exp_mem) begin
            $display("FAILED time=%0t signal=mem_cmd_o expected=%h actual=%h",
                     $time, exp_mem, mem_cmd_i);
            value_errors_o++;
          end
        end
      end
      // LCE commands in response order
      if (lce_cmd_v_i && lce_cmd_ready_i) begin
        if (exp_lce_q.size() == 0) begin
          $display("LCE command at %0t with no memory response behind it", $time);
          other_errors_o++;
        end else begin
          exp_lce = exp_lce_q.pop_front();
          if (lce_cmd_i !== exp_lce) begin
            $display("FAILED time=%0t signal=lce_cmd_o expected=%h actual=%h",
                     $time, exp_lce, lce_cmd_i);
            value_errors_o++;
          end
        end
      end
      // normal mode must stay silent
      if (cce_mode_i == e_cce_mode_normal && (mem_cmd_v_i || lce_cmd_v_i)) begin
        $display("output valid at %0t while the CCE is in normal mode", $time);
        other_errors_o++;
      end
    end
  end

  // expected items that never showed up
  function automatic int report_leftovers();
    if (exp_mem_q.size() != 0) begin
      $display("%0d expected memory commands never appeared", exp_mem_q.size());
    end
    if (exp_lce_q.size() != 0) begin
      $display("%0d expected LCE commands never appeared", exp_lce_q.size());
    end
    return exp_mem_q.size() + exp_lce_q.size();
  endfunction

endmodule

// File: verification/uc_cce_tb.sv
// Uncached CCE testbench
`timescale 1ns/1ps

module uc_cce_tb;

  import uc_pkg::*;

  // 4 store/load pairs, random beats, 2 beats in the mode test
  localparam int n_rand  = 40;
  localparam int num_txn = 8 + n_rand + 2;

  logic                    clk_i;
  logic                    arst_n_i;
  logic [cce_id_width-1:0] cce_id_i;
  cce_mode_e               cce_mode_i;
  lce_req_s                lce_req_i;
  logic                    lce_req_v_i;
  logic                    lce_req_ready_o;
  mem_msg_s                mem_resp_i;
  logic                    mem_resp_v_i;
  logic                    mem_resp_ready_o;
  lce_cmd_s                lce_cmd_o;
  logic                    lce_cmd_v_o;
  logic                    lce_cmd_ready_i;
  mem_msg_s                mem_cmd_o;
  logic                    mem_cmd_v_o;
  logic                    mem_cmd_ready_i;

  logic [31:0]             lfsr_state;
  logic [dword_width-1:0]  mem [64];
  mem_msg_s                resp_q[$];
  mem_msg_s                resp;
  logic [63:0]             ready_bits;
  logic [63:0]             last_load;
  int                      sent_count;
  int                      done_count;
  int                      load_errors;
  int                      level_errors;
  int                      leftovers;
  int                      value_errors;
  int                      other_errors;

  uc_cce_top UUT (.*);

  uc_cce_checker msg_check (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .cce_id_i        (cce_id_i),
    .cce_mode_i      (cce_mode_i),
    .req_i           (lce_req_i),
    .req_fire_i      (lce_req_v_i & lce_req_ready_o),
    .resp_i          (mem_resp_i),
    .resp_fire_i     (mem_resp_v_i & mem_resp_ready_o),
    .lce_cmd_i       (lce_cmd_o),
    .lce_cmd_v_i     (lce_cmd_v_o),
    .lce_cmd_ready_i (lce_cmd_ready_i),
    .mem_cmd_i       (mem_cmd_o),
    .mem_cmd_v_i     (mem_cmd_v_o),
    .mem_cmd_ready_i (mem_cmd_ready_i),
    .value_errors_o  (value_errors),
    .other_errors_o  (other_errors)
  );

  // fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // n random bits, one LFSR step each
  task automatic draw_bits(input int n, output logic [63:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val        = {val[62:0], lfsr_state[0]};
    end
  endtask

  // one request beat, ready is stable at the falling edge
  task automatic send_req(input lce_req_type_e kind, input uc_size_e size,
                          input logic [31:0] addr, input logic [63:0] data,
                          input logic [1:0] src);
    @(negedge clk_i);
    lce_req_i.src_id   = src;
    lce_req_i.msg_type = kind;
    lce_req_i.uc_size  = size;
    lce_req_i.addr     = addr;
    lce_req_i.data     = data;
    lce_req_v_i        = 1'b1;
    while (!lce_req_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    lce_req_v_i = 1'b0;
    sent_count++;
  endtask

  // every request has come back as an LCE command
  task automatic wait_drained();
    while (done_count != sent_count) @(negedge clk_i);
  endtask

  task automatic check_load(input logic [63:0] exp);
    if (last_load !== exp) begin
      $display("FAILED time=%0t signal=lce_cmd_o.data expected=%h actual=%h",
               $time, exp, last_load);
      load_errors++;
    end
  endtask

  // one ready or valid output against its expected level
  task automatic check_level(input string name, input logic actual, input logic exp);
    if (actual !== exp) begin
      $display("FAILED time=%0t signal=%s expected=%b actual=%b",
               $time, name, exp, actual);
      level_errors++;
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // random back-pressure on both outbound ports
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      draw_bits(2, ready_bits);
      lce_cmd_ready_i = ready_bits[0];
      mem_cmd_ready_i = ready_bits[1];
    end
  end

  // memory model, writes land at acceptance, responses queue in order
  always @(posedge clk_i) begin
    if (arst_n_i && mem_cmd_v_o && mem_cmd_ready_i) begin
      resp = mem_cmd_o;
      if (mem_cmd_o.msg_type == e_mem_uc_wr) begin
        mem[mem_cmd_o.addr[8:3]] = mem_cmd_o.data;
        resp.data                = '0;
      end else begin
        resp.data = mem[mem_cmd_o.addr[8:3]];
      end
      resp_q.push_back(resp);
    end
  end

  // response driver with random delay
  initial begin
    logic [63:0] gap;
    forever begin
      @(negedge clk_i);
      if (resp_q.size() != 0) begin
        draw_bits(2, gap);
        repeat (gap) @(negedge clk_i);
        mem_resp_i   = resp_q.pop_front();
        mem_resp_v_i = 1'b1;
        while (!mem_resp_ready_o) @(negedge clk_i);
        @(negedge clk_i);
        mem_resp_v_i = 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin
    if (arst_n_i && lce_cmd_v_o && lce_cmd_ready_i) begin
      done_count++;
      if (lce_cmd_o.msg_type == e_lce_cmd_uc_data) begin
        last_load = lce_cmd_o.data;
      end
    end
  end

  initial begin
    repeat (num_txn * 200) @(posedge clk_i);
    $display("watchdog expired before all transactions finished");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    logic [63:0] r;
    logic [63:0] d;
    lfsr_state      = 32'h16cfff6f;
    arst_n_i        = 1'b0;
    cce_id_i        = 2'd2;
    cce_mode_i      = e_cce_mode_uncached;
    lce_req_i       = '0;
    lce_req_v_i     = 1'b0;
    mem_resp_i      = '0;
    mem_resp_v_i    = 1'b0;
    lce_cmd_ready_i = 1'b0;
    mem_cmd_ready_i = 1'b0;
    sent_count      = 0;
    done_count      = 0;
    load_errors     = 0;
    level_errors    = 0;
    // fill derived from the word index
    for (int i = 0; i < 64; i++) begin
      mem[i] = {32'h5eed0000 + i, 32'hffffffff - i * 32'h01010101};
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    // buffers come out of reset empty and nothing is offered
    check_level("lce_req_ready_o", lce_req_ready_o, 1'b1);
    check_level("mem_resp_ready_o", mem_resp_ready_o, 1'b1);
    check_level("lce_cmd_v_o", lce_cmd_v_o, 1'b0);
    check_level("mem_cmd_v_o", mem_cmd_v_o, 1'b0);
    // store then load back, once per size
    for (int s = 0; s < 4; s++) begin
      draw_bits(64, d);
      send_req(e_lce_req_uc_wr, uc_size_e'(s[1:0]), 32'h100 + 8 * s, d, s[1:0]);
      send_req(e_lce_req_uc_rd, uc_size_e'(s[1:0]), 32'h100 + 8 * s, 64'hdead, ~s[1:0]);
      wait_drained();
      check_load(d);
    end
    // random mix, nonzero read data must not leak to memory
    for (int i = 0; i < n_rand; i++) begin
      draw_bits(11, r);
      draw_bits(64, d);
      send_req(lce_req_type_e'(r[0]), uc_size_e'(r[2:1]), {23'h4000, r[8:3], 3'b000},
               d, r[10:9]);
      draw_bits(2, r);
      repeat (r) @(negedge clk_i);
    end
    wait_drained();
    // requests park in the buffer until uncached mode returns
    @(negedge clk_i);
    cce_mode_i = e_cce_mode_normal;
    send_req(e_lce_req_uc_wr, e_uc_size_8, 32'h200, 64'h0123456789abcdef, 2'd3);
    send_req(e_lce_req_uc_rd, e_uc_size_8, 32'h200, 64'h0, 2'd0);
    repeat (20) @(negedge clk_i);
    // two parked requests fill the request buffer
    check_level("lce_req_ready_o", lce_req_ready_o, 1'b0);
    cce_mode_i = e_cce_mode_uncached;
    wait_drained();
    check_load(64'h0123456789abcdef);
    repeat (4) @(negedge clk_i);
    leftovers = msg_check.report_leftovers();
    $display("errors: %0d value, %0d other, %0d load, %0d level, %0d leftover",
             value_errors, other_errors, load_errors, level_errors, leftovers);
    if (value_errors + other_errors + load_errors + level_errors + leftovers == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
